// File: verilog/rvviTracePkg.sv
/*
 * Shared widths, CSR slot order and trace record layouts for the RVFI to
 * RVVI trace converter. Modules and the testbench model reach everything
 * here by scoped name.
 */
package rvviTracePkg;

    ////////////////////
    // Widths
    ////////////////////

    // Register and PC width
    localparam int xlen = 32;
    // Retirement counter
    localparam int orderWidth = 64;
    // Integer register file
    localparam int numGpr = 32;
    localparam int gprAddrWidth = $clog2(numGpr);
    // Destination register ports per retirement
    localparam int numRdPorts = 2;
    // Core interrupt vector
    localparam int numIrq = 32;

    ////////////////////
    // CSR slots
    ////////////////////

    // Traced CSRs by slot, no addresses needed
    typedef enum logic [3:0] {
        slotMstatus,
        slotMisa,
        slotMie,
        slotMtvec,
        slotMscratch,
        slotMepc,
        slotMcause,
        slotMip,
        slotDcsr,
        slotDpc
    } csrSlot_e;

    // Last slot closes the list
    localparam int numCsrSlots = int'(slotDpc) + 1;

    // Software, timer, external and the sixteen local lines
    localparam logic [numIrq-1:0] irqUsedMask = 32'hFFFF_0888;

    ////////////////////
    // Records
    ////////////////////

    // One retirement as the core reports it
    typedef struct packed {
        logic                  valid;
        logic [orderWidth-1:0] order;
        logic [xlen-1:0]       insn;
        logic                  trap;
        logic                  intr;
        logic [1:0]            mode;
        logic [1:0]            ixl;
        logic [xlen-1:0]       pc;
    } rvfiRetire_t;

    // Same retirement on the reference-model side
    typedef struct packed {
        logic                  valid;
        logic [orderWidth-1:0] order;
        logic [xlen-1:0]       insn;
        logic                  trap;
        logic                  intr;
        logic [1:0]            mode;
        logic [1:0]            ixl;
        logic [xlen-1:0]       pc;
    } rvviRetire_t;

    // Read, write and mask of one CSR
    typedef struct packed {
        logic [xlen-1:0] rdata;
        logic [xlen-1:0] wdata;
        logic [xlen-1:0] wmask;
    } rvfiCsr_t;

    // All traced CSRs, indexed by csrSlot_e
    typedef rvfiCsr_t [numCsrSlots-1:0] rvfiCsrBus_t;

    // Architectural CSR values plus changed flags
    typedef struct packed {
        logic [numCsrSlots-1:0][xlen-1:0] value;
        logic [numCsrSlots-1:0]           csrWb;
    } rvviCsr_t;

    // Destination register ports
    typedef struct packed {
        logic [numRdPorts-1:0][gprAddrWidth-1:0] rdAddr;
        logic [numRdPorts-1:0][xlen-1:0]         rdWdata;
    } rvfiGpr_t;

    // GPR write-back per register
    typedef struct packed {
        logic [numGpr-1:0]           xWb;
        logic [numGpr-1:0][xlen-1:0] xWdata;
    } rvviGpr_t;

    // Net change strobes and current levels
    typedef struct packed {
        logic [numIrq-1:0] irqChanged;
        logic [numIrq-1:0] irqLevel;
        logic              haltChanged;
        logic              haltLevel;
    } netEvent_t;

endpackage

// File: verilog/retireCapture.sv
/*
 * Registers the per-instruction retirement fields into the RVVI record.
 * One cycle of latency, a new retirement may enter every cycle.
 */
module retireCapture (
    input  logic                      rvvi_i,
    input  logic                      rstN_i,
    input  rvviTracePkg::rvfiRetire_t rfvi_i,
    output rvviTracePkg::rvviRetire_t rvvi_o
);

    // Next record, built field by field
    rvviTracePkg::rvviRetire_t retireNext;

    ////////////////////
    // Next record
    ////////////////////

    always_comb begin
        retireNext.valid = rfvi_i.valid;
        retireNext.order = rfvi_i.order;
        retireNext.insn  = rfvi_i.insn;
        // Trap only counts with a retirement behind it
        retireNext.trap  = rfvi_i.valid & rfvi_i.trap;
        retireNext.intr  = rfvi_i.intr;
        retireNext.mode  = rfvi_i.mode;
        retireNext.ixl   = rfvi_i.ixl;
        retireNext.pc    = rfvi_i.pc;
    end

    ////////////////////
    // Output register
    ////////////////////

    always_ff @(posedge rvvi_i or negedge rstN_i) begin
        if (!rstN_i) begin
            // Whole record clears, valid low first of all
            rvvi_o <= '0;
        end else begin
            rvvi_o <= retireNext;
        end
    end

endmodule

// File: verilog/csrTrace.sv
/*
 * Merges each traced CSR from RVFI read data, write data and write mask.
 * Holds the last merged value per slot and flags the slots whose value
 * changed on a valid retirement.
 */
module csrTrace (
    input  logic                      rvvi_i,
    input  logic                      rstN_i,
    input  logic                      retireValid_i,
    input  rvviTracePkg::rvfiCsrBus_t csr_i,
    output rvviTracePkg::rvviCsr_t    csr_o
);

    // Merged value per slot for this cycle
    logic [rvviTracePkg::numCsrSlots-1:0][rvviTracePkg::xlen-1:0] csrMerged;
    // Change flags for this cycle
    logic [rvviTracePkg::numCsrSlots-1:0]                         csrWbNext;

    ////////////////////
    // Masked merge
    ////////////////////

    always_comb begin
        for (int s = 0; s < rvviTracePkg::numCsrSlots; s++) begin
            // Written bits from wdata
            // untouched bits from rdata
            csrMerged[s] = (csr_i[s].wdata & csr_i[s].wmask)
                         | (csr_i[s].rdata & ~csr_i[s].wmask);
            // Compare against the held value
            csrWbNext[s] = retireValid_i && (csrMerged[s] != csr_o.value[s]);
        end
    end

    ////////////////////
    // Held values
    ////////////////////

    always_ff @(posedge rvvi_i or negedge rstN_i) begin
        if (!rstN_i) begin
            csr_o <= '0;
        end else begin
            // Strobes last one cycle
            csr_o.csrWb <= csrWbNext;
            // Values hold across idle cycles
            if (retireValid_i) begin
                csr_o.value <= csrMerged;
            end
        end
    end

endmodule

// File: verilog/gprTrace.sv
/*
 * Turns the two RVFI destination-register ports into the RVVI write-back
 * vector and register-value array, registered once. Port 1 wins a tie and
 * register 0 is never marked.
 */
module gprTrace (
    input  logic                   rvvi_i,
    input  logic                   rstN_i,
    input  logic                   retireValid_i,
    input  rvviTracePkg::rvfiGpr_t gpr_i,
    output rvviTracePkg::rvviGpr_t gpr_o
);

    // Write-back record for this cycle
    rvviTracePkg::rvviGpr_t gprNext;

    ////////////////////
    // Port decode
    ////////////////////

    always_comb begin
        // Unwritten entries read zero
        gprNext = '0;
        if (retireValid_i) begin
            // Ascending port order, so the higher port overrides
            for (int p = 0; p < rvviTracePkg::numRdPorts; p++) begin
                // x0 writes are dropped
                if (gpr_i.rdAddr[p] != '0) begin
                    gprNext.xWb[gpr_i.rdAddr[p]]    = 1'b1;
                    gprNext.xWdata[gpr_i.rdAddr[p]] = gpr_i.rdWdata[p];
                end
            end
        end
    end

    ////////////////////
    // Output register
    ////////////////////

    always_ff @(posedge rvvi_i or negedge rstN_i) begin
        if (!rstN_i) begin
            gpr_o <= '0;
        end else begin
            // Idle cycle gives an all-zero record
            gpr_o <= gprNext;
        end
    end

endmodule

// File: verilog/netTrace.sv
/*
 * Change detection on the used interrupt lines and the halt request.
 * Reports a one-cycle change strobe with the new level, one cycle late.
 */
module netTrace (
    input  logic                                rvvi_i,
    input  logic                                rstN_i,
    input  logic [rvviTracePkg::numIrq-1:0]     irq_i,
    input  logic                                debugReq_i,
    output rvviTracePkg::netEvent_t             net_o
);

    // Lines outside the mask never report
    logic [rvviTracePkg::numIrq-1:0] irqUsed;

    assign irqUsed = irq_i & rvviTracePkg::irqUsedMask;

    ////////////////////
    // Level and edge
    ////////////////////

    // Output levels double as the previous sample
    always_ff @(posedge rvvi_i or negedge rstN_i) begin
        if (!rstN_i) begin
            net_o <= '0;
        end else begin
            net_o.irqChanged  <= irqUsed ^ net_o.irqLevel;
            net_o.irqLevel    <= irqUsed;
            // Halt request, same rule on one line
            net_o.haltChanged <= debugReq_i ^ net_o.haltLevel;
            net_o.haltLevel   <= debugReq_i;
        end
    end

endmodule

// File: verilog/rvfiToRvvi.sv
/*
 * Top of the RVFI to RVVI trace converter. Every input is sampled on the
 * rising edge of rvvi_i and every output is one register stage later.
 */
module rvfiToRvvi (
    input  logic                                rvvi_i,
    input  logic                                rstN_i,
    input  rvviTracePkg::rvfiRetire_t           rvfiRetire_i,
    input  rvviTracePkg::rvfiCsrBus_t           rvfiCsr_i,
    input  rvviTracePkg::rvfiGpr_t              rvfiGpr_i,
    input  logic [rvviTracePkg::numIrq-1:0]     irq_i,
    input  logic                                debugReq_i,
    output rvviTracePkg::rvviRetire_t           rvviRetire_o,
    output rvviTracePkg::rvviCsr_t              rvviCsr_o,
    output rvviTracePkg::rvviGpr_t              rvviGpr_o,
    output rvviTracePkg::netEvent_t             netEvent_o
);

    // Retire valid gates the CSR and GPR stages
    logic retireValid;

    assign retireValid = rvfiRetire_i.valid;

    ////////////////////
    // Trace stages
    ////////////////////

    retireCapture retireCapture_inst (
        .rvvi_i (rvvi_i),
        .rstN_i (rstN_i),
        .rfvi_i (rvfiRetire_i),
        .rvvi_o (rvviRetire_o)
    );

    csrTrace csrTrace_inst (
        .rvvi_i        (rvvi_i),
        .rstN_i        (rstN_i),
        .retireValid_i (retireValid),
        .csr_i         (rvfiCsr_i),
        .csr_o         (rvviCsr_o)
    );

    gprTrace gprTrace_inst (
        .rvvi_i        (rvvi_i),
        .rstN_i        (rstN_i),
        .retireValid_i (retireValid),
        .gpr_i         (rvfiGpr_i),
        .gpr_o         (rvviGpr_o)
    );

    // Nets run free of retirement
    netTrace netTrace_inst (
        .rvvi_i     (rvvi_i),
        .rstN_i     (rstN_i),
        .irq_i      (irq_i),
        .debugReq_i (debugReq_i),
        .net_o      (netEvent_o)
    );

endmodule

// File: test/traceModel.svh
/*
 * Reference model of the four trace conversions, included in the testbench
 * module body. Holds its own CSR values and previous net levels and
 * predicts the records that appear one rising edge later.
 */
`ifndef TRACE_MODEL_SVH
`define TRACE_MODEL_SVH

// Last architectural value per CSR slot
logic [rvviTracePkg::xlen-1:0]   heldCsr [rvviTracePkg::numCsrSlots];
// Levels seen at the previous edge
logic [rvviTracePkg::numIrq-1:0] prevIrq;
logic                            prevHalt;

// Software, timer, external, then local lines 16 and up
function automatic logic [rvviTracePkg::numIrq-1:0] usedIrqLines();
    logic [rvviTracePkg::numIrq-1:0] lines;
    lines = '0;
    lines[3] = 1'b1;
    lines[7] = 1'b1;
    lines[11] = 1'b1;
    lines[31:16] = '1;
    return lines;
endfunction

task automatic resetModel();
    for (int s = 0; s < rvviTracePkg::numCsrSlots; s++) begin
        heldCsr[s] = '0;
    end
    prevIrq = '0;
    prevHalt = 1'b0;
endtask

// Straight copy, trap only with valid
function automatic rvviTracePkg::rvviRetire_t predictRetire(input rvviTracePkg::rvfiRetire_t r);
    rvviTracePkg::rvviRetire_t res;
    res.valid = r.valid;
    res.order = r.order;
    res.insn = r.insn;
    res.trap = r.valid ? r.trap : 1'b0;
    res.intr = r.intr;
    res.mode = r.mode;
    res.ixl = r.ixl;
    res.pc = r.pc;
    return res;
endfunction

task automatic predictCsr(input logic valid, input rvviTracePkg::rvfiCsrBus_t bus,
                          output rvviTracePkg::rvviCsr_t res);
    logic [rvviTracePkg::xlen-1:0] merged;
    res = '0;
    for (int s = 0; s < rvviTracePkg::numCsrSlots; s++) begin
        // Per bit: mask picks write data over read data
        for (int b = 0; b < rvviTracePkg::xlen; b++) begin
            merged[b] = bus[s].wmask[b] ? bus[s].wdata[b] : bus[s].rdata[b];
        end
        if (valid) begin
            res.csrWb[s] = (merged != heldCsr[s]);
            heldCsr[s] = merged;
        end
        res.value[s] = heldCsr[s];
    end
endtask

// Port 1 first, port 0 only on a different register
function automatic rvviTracePkg::rvviGpr_t predictGpr(input logic valid,
                                                      input rvviTracePkg::rvfiGpr_t gpr);
    rvviTracePkg::rvviGpr_t res;
    res = '0;
    if (valid) begin
        if (gpr.rdAddr[1] != 5'd0) begin
            res.xWb[gpr.rdAddr[1]] = 1'b1;
            res.xWdata[gpr.rdAddr[1]] = gpr.rdWdata[1];
        end
        if (gpr.rdAddr[0] != 5'd0 && gpr.rdAddr[0] != gpr.rdAddr[1]) begin
            res.xWb[gpr.rdAddr[0]] = 1'b1;
            res.xWdata[gpr.rdAddr[0]] = gpr.rdWdata[0];
        end
    end
    return res;
endfunction

task automatic predictNet(input logic [rvviTracePkg::numIrq-1:0] irqIn, input logic haltIn,
                          output rvviTracePkg::netEvent_t res);
    logic [rvviTracePkg::numIrq-1:0] used;
    used = irqIn & usedIrqLines();
    res.irqChanged = used ^ prevIrq;
    res.irqLevel = used;
    res.haltChanged = haltIn ^ prevHalt;
    res.haltLevel = haltIn;
    prevIrq = used;
    prevHalt = haltIn;
endtask

`endif

// File: test/tbRvfiToRvvi.sv
/*
 * Testbench for the RVFI to RVVI trace converter. Random retirements, CSR
 * updates, rd writes and net toggles from a fixed seed, checked each cycle
 * against the included reference model.
 */
module tbRvfiToRvvi;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clkPeriod = 100;
    localparam int numCycles = 400;

    logic rvvi = 1'b0;
    logic rstN;

    // DUT inputs
    rvviTracePkg::rvfiRetire_t       rvfiRetire;
    rvviTracePkg::rvfiCsrBus_t       rvfiCsr;
    rvviTracePkg::rvfiGpr_t          rvfiGpr;
    logic [rvviTracePkg::numIrq-1:0] irq;
    logic                            debugReq;

    // DUT outputs
    rvviTracePkg::rvviRetire_t rvviRetire;
    rvviTracePkg::rvviCsr_t    rvviCsr;
    rvviTracePkg::rvviGpr_t    rvviGpr;
    rvviTracePkg::netEvent_t   netEvent;

    // Expected records for the next check
    rvviTracePkg::rvviRetire_t expRetire;
    rvviTracePkg::rvviCsr_t    expCsr;
    rvviTracePkg::rvviGpr_t    expGpr;
    rvviTracePkg::netEvent_t   expNet;

    `include "traceModel.svh"

    rvfiToRvvi rvfiToRvvi_inst (
        .rvvi_i       (rvvi),
        .rstN_i       (rstN),
        .rvfiRetire_i (rvfiRetire),
        .rvfiCsr_i    (rvfiCsr),
        .rvfiGpr_i    (rvfiGpr),
        .irq_i        (irq),
        .debugReq_i   (debugReq),
        .rvviRetire_o (rvviRetire),
        .rvviCsr_o    (rvviCsr),
        .rvviGpr_o    (rvviGpr),
        .netEvent_o   (netEvent)
    );

    always #(clkPeriod / 2) rvvi = ~rvvi;

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic failRun();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compareField(input string name, input logic [63:0] expVal,
                                input logic [63:0] actVal);
        if (actVal !== expVal) begin
            $display("[FAIL] %s expected 0x%0h actual 0x%0h at %0t", name, expVal, actVal, $time);
            failRun();
        end
    endtask

    task automatic checkRetire(input rvviTracePkg::rvviRetire_t expRec,
                               input rvviTracePkg::rvviRetire_t actRec);
        // Stale trap must never show
        if (!actRec.valid && actRec.trap) begin
            $display("Trap flag is high on a cycle without a valid retirement at %0t", $time);
            failRun();
        end
        compareField("rvviRetire_o.valid", 64'(expRec.valid), 64'(actRec.valid));
        compareField("rvviRetire_o.order", expRec.order, actRec.order);
        compareField("rvviRetire_o.insn", 64'(expRec.insn), 64'(actRec.insn));
        compareField("rvviRetire_o.trap", 64'(expRec.trap), 64'(actRec.trap));
        compareField("rvviRetire_o.intr", 64'(expRec.intr), 64'(actRec.intr));
        compareField("rvviRetire_o.mode", 64'(expRec.mode), 64'(actRec.mode));
        compareField("rvviRetire_o.ixl", 64'(expRec.ixl), 64'(actRec.ixl));
        compareField("rvviRetire_o.pc", 64'(expRec.pc), 64'(actRec.pc));
    endtask

    task automatic checkCsr(input rvviTracePkg::rvviCsr_t expRec,
                            input rvviTracePkg::rvviCsr_t actRec);
        compareField("rvviCsr_o.csrWb", 64'(expRec.csrWb), 64'(actRec.csrWb));
        for (int s = 0; s < rvviTracePkg::numCsrSlots; s++) begin
            compareField($sformatf("rvviCsr_o.value[%0d]", s),
                         64'(expRec.value[s]), 64'(actRec.value[s]));
        end
    endtask

    task automatic checkGpr(input rvviTracePkg::rvviGpr_t expRec,
                            input rvviTracePkg::rvviGpr_t actRec);
        compareField("rvviGpr_o.xWb", 64'(expRec.xWb), 64'(actRec.xWb));
        for (int g = 0; g < rvviTracePkg::numGpr; g++) begin
            compareField($sformatf("rvviGpr_o.xWdata[%0d]", g),
                         64'(expRec.xWdata[g]), 64'(actRec.xWdata[g]));
        end
    endtask

    task automatic checkNet(input rvviTracePkg::netEvent_t expRec,
                            input rvviTracePkg::netEvent_t actRec);
        compareField("netEvent_o.irqChanged", 64'(expRec.irqChanged), 64'(actRec.irqChanged));
        compareField("netEvent_o.irqLevel", 64'(expRec.irqLevel), 64'(actRec.irqLevel));
        compareField("netEvent_o.haltChanged", 64'(expRec.haltChanged),
                     64'(actRec.haltChanged));
        compareField("netEvent_o.haltLevel", 64'(expRec.haltLevel), 64'(actRec.haltLevel));
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic driveRandom();
        logic [31:0] r;
        logic [31:0] sel;
        logic [31:0] flip;
        r = $urandom();
        // Mostly valid, trap drawn on its own
        rvfiRetire.valid = (r[1:0] != 2'b00);
        rvfiRetire.trap = r[2];
        rvfiRetire.intr = r[3];
        rvfiRetire.mode = r[5:4];
        rvfiRetire.ixl = r[7:6];
        rvfiRetire.order = {$urandom(), $urandom()};
        rvfiRetire.insn = $urandom();
        rvfiRetire.pc = $urandom();
        for (int s = 0; s < rvviTracePkg::numCsrSlots; s++) begin
            sel = $urandom();
            rvfiCsr[s].rdata = $urandom();
            rvfiCsr[s].wdata = $urandom();
            case (sel[1:0])
                2'd0: rvfiCsr[s].wmask = '0;
                2'd1: rvfiCsr[s].wmask = '1;
                default: rvfiCsr[s].wmask = $urandom();
            endcase
            // Now and then replay the held value, no write-back expected
            if (sel[4:2] == 3'd0) begin
                rvfiCsr[s].rdata = heldCsr[s];
                rvfiCsr[s].wmask = '0;
            end
        end
        for (int p = 0; p < rvviTracePkg::numRdPorts; p++) begin
            sel = $urandom();
            rvfiGpr.rdAddr[p] = (sel[7:5] == 3'd0) ? 5'd0 : sel[4:0];
            rvfiGpr.rdWdata[p] = $urandom();
        end
        // Same register on both ports
        r = $urandom();
        if (r[1:0] == 2'd0) begin
            rvfiGpr.rdAddr[1] = rvfiGpr.rdAddr[0];
        end
        // Sparse toggles on the nets
        flip = $urandom() & $urandom() & $urandom();
        irq = irq ^ flip;
        if (r[4:2] == 3'd0) begin
            debugReq = ~debugReq;
        end
    endtask

    task automatic stepModel();
        expRetire = predictRetire(rvfiRetire);
        predictCsr(rvfiRetire.valid, rvfiCsr, expCsr);
        expGpr = predictGpr(rvfiRetire.valid, rvfiGpr);
        predictNet(irq, debugReq, expNet);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        rstN = 1'b0;
        rvfiRetire = '0;
        rvfiCsr = '0;
        rvfiGpr = '0;
        irq = '0;
        debugReq = 1'b0;
        void'($urandom(32'hb85b));
        resetModel();
        if (usedIrqLines() !== rvviTracePkg::irqUsedMask) begin
            $display("Package interrupt mask does not match the used interrupt lines");
            failRun();
        end
        repeat (2) @(posedge rvvi);
        @(negedge rvvi);
        // Reset state, everything cleared
        expRetire = '0;
        expCsr = '0;
        expGpr = '0;
        expNet = '0;
        checkRetire(expRetire, rvviRetire);
        checkCsr(expCsr, rvviCsr);
        checkGpr(expGpr, rvviGpr);
        checkNet(expNet, netEvent);
        rstN = 1'b1;
        for (int c = 0; c < numCycles; c++) begin
            driveRandom();
            stepModel();
            // Outputs settled after the rising edge
            @(negedge rvvi);
            checkRetire(expRetire, rvviRetire);
            checkCsr(expCsr, rvviCsr);
            checkGpr(expGpr, rvviGpr);
            checkNet(expNet, netEvent);
        end
        $display("Test completed successfully");
        $finish;
    end

    // Watchdog
    initial begin
        #((numCycles + 20) * clkPeriod);
        $display("Timeout: the stimulus loop did not finish in the expected time");
        failRun();
    end

endmodule

// File: files.f
+incdir+test
verilog/rvviTracePkg.sv
verilog/retireCapture.sv
verilog/csrTrace.sv
verilog/gprTrace.sv
verilog/netTrace.sv
verilog/rvfiToRvvi.sv
test/tbRvfiToRvvi.sv

// File: run.sh
#!/bin/sh
# Build and run the trace converter testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf build sim.log

verilator --binary --timing --timescale 1ns/1ps \
    -f files.f \
    --top-module tbRvfiToRvvi \
    --Mdir build \
    -o simTb

# Log is kept whatever the simulator exit code
./build/simTb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test completed successfully" sim.log; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed, see sim.log"
exit 1
